/* all.f */
+incdir+include
hdl/icache_pkg.sv
hdl/icache_array_if.sv
hdl/icache_array.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
sim/icache_asserts.sv
sim/icache_checker.sv
sim/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - include
    files:
      - hdl/icache_pkg.sv
      - hdl/icache_array_if.sv
      - hdl/icache_array.sv
      - hdl/icache_ctrl.sv
      - hdl/icache_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - sim/icache_asserts.sv
      - sim/icache_checker.sv
      - sim/icache_tb.sv

/* sim/icache_tb.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tb;

    localparam int unsigned N_REQ          = 400;
    localparam int unsigned RESET_CYCLES   = 16;
    // Gap, handshake, lookup, up to 8 memory cycles and the response
    localparam int unsigned WORST_CYCLES   = 16;
    localparam int unsigned TIMEOUT_CYCLES = N_REQ * WORST_CYCLES + RESET_CYCLES;
    localparam logic [31:0] SEED           = 32'he736;

    logic                         clk;
    logic                         rst;
    logic [`ICACHE_ADDR_BITS-1:0] cpu_req_addr;
    logic                         cpu_req_valid;
    logic                         cpu_req_ready;
    logic [`ICACHE_DATA_BITS-1:0] cpu_resp_data;
    logic                         cpu_resp_valid;
    logic [`ICACHE_ADDR_BITS-1:0] mem_req_addr;
    logic                         mem_req_valid;
    logic                         mem_req_ready;
    logic [`ICACHE_DATA_BITS-1:0] mem_req_data;

    int unsigned error_count;
    int unsigned resp_count;
    int unsigned tb_errors;
    int unsigned assert_errors;
    int unsigned sent;
    int unsigned cycles;
    int unsigned gap;
    int unsigned mem_wait;
    logic        mem_busy;
    logic        timed_out;
    logic [31:0] lfsr_state;

    icache_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_data  (cpu_resp_data),
        .cpu_resp_valid (cpu_resp_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_data   (mem_req_data)
    );

    icache_checker checker0 (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_data  (cpu_resp_data),
        .cpu_resp_valid (cpu_resp_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .error_count    (error_count),
        .resp_count     (resp_count)
    );

    bind icache_ctrl icache_asserts asserts0 (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    function automatic logic [31:0] draw_bits(input int unsigned n);
        logic [31:0] v;
        int unsigned k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Only four tags so lines get reused and evicted often
    function automatic icache_pkg::tag_t pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    return 26'h000_0000;
            2'd1:    return 26'h000_0001;
            2'd2:    return 26'h2A5_F0C3;
            default: return 26'h3FF_FFFF;
        endcase
    endfunction

    function automatic logic [31:0] make_addr();
        logic [1:0] sel;
        logic [3:0] idx;
        logic [1:0] off;
        sel = 2'(draw_bits(2));
        idx = 4'(draw_bits(4));
        off = 2'(draw_bits(2));
        return {pick_tag(sel), idx, off};
    endfunction

    function automatic logic [31:0] memory_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5A3C_96E1 ^ {a[28:0], 3'b000};
    endfunction

    task automatic drive_memory();
        if (mem_req_ready)
        begin
            mem_req_ready <= 1'b0;
        end
        else if (mem_req_valid)
        begin
            if (!mem_busy)
            begin
                mem_busy = 1'b1;
                mem_wait = draw_bits(3);
            end
            if (mem_wait == 0)
            begin
                mem_req_ready <= 1'b1;
                mem_req_data  <= memory_word(mem_req_addr);
                mem_busy = 1'b0;
            end
            else
            begin
                mem_wait--;
            end
        end
    endtask

    task automatic drive_cpu();
        if (cpu_req_valid && cpu_req_ready)
        begin
            cpu_req_valid <= 1'b0;
            sent++;
            gap = draw_bits(2);
        end
        else if (!cpu_req_valid && sent < N_REQ)
        begin
            if (gap == 0)
            begin
                cpu_req_valid <= 1'b1;
                cpu_req_addr  <= make_addr();
            end
            else
            begin
                gap--;
            end
        end
    endtask

    initial
    begin
        clk           = 1'b0;
        rst           = 1'b1;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        mem_req_ready = 1'b0;
        mem_req_data  = '0;
        lfsr_state    = SEED;
        tb_errors     = 0;
        assert_errors = 0;
        sent          = 0;
        gap           = 0;
        mem_wait      = 0;
        mem_busy      = 1'b0;
        timed_out     = 1'b0;
        cycles        = RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        while (resp_count < N_REQ && !timed_out)
        begin
            @(posedge clk);
            cycles++;
            drive_memory();
            drive_cpu();
            if (cycles >= TIMEOUT_CYCLES)
                timed_out = 1'b1;
        end

        // Let any stray strobe reach the checker
        repeat (4) @(posedge clk);

        assert_errors = dut0.ctrl0.asserts0.fail_count;

        if (timed_out)
        begin
            tb_errors++;
            $display("Timeout after %0d cycles with %0d of %0d responses",
                     cycles, resp_count, N_REQ);
        end
        if (resp_count != sent)
        begin
            tb_errors++;
            $display("%0d requests accepted but %0d responses seen", sent, resp_count);
        end
        $display("Requests %0d responses %0d checker errors %0d tb errors %0d assert errors %0d",
                 sent, resp_count, error_count, tb_errors, assert_errors);
        if (error_count == 0 && tb_errors == 0 && assert_errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

/* sim/icache_checker.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`ICACHE_ADDR_BITS-1:0] cpu_req_addr,
    input  logic                         cpu_req_valid,
    input  logic                         cpu_req_ready,
    input  logic [`ICACHE_DATA_BITS-1:0] cpu_resp_data,
    input  logic                         cpu_resp_valid,
    input  logic [`ICACHE_ADDR_BITS-1:0] mem_req_addr,
    input  logic                         mem_req_valid,
    input  logic                         mem_req_ready,
    output int unsigned                  error_count,
    output int unsigned                  resp_count
);

    // Longest miss is about 11 cycles with the slowest memory
    localparam int unsigned MAX_WAIT = 16;

    logic                         shadow_valid [`ICACHE_LINES];
    icache_pkg::tag_t             shadow_tag [`ICACHE_LINES];
    logic                         busy;
    logic                         expect_hit;
    logic [`ICACHE_ADDR_BITS-1:0] cur_addr;
    logic [`ICACHE_ADDR_BITS-1:0] word_addr;
    icache_pkg::index_t           cur_index;
    icache_pkg::tag_t             cur_tag;
    int unsigned                  lat;
    int unsigned                  mem_count;
    int unsigned                  errs;
    int unsigned                  resps;
    int                           i;

    // Same scramble the memory model applies to a word address
    function automatic logic [`ICACHE_DATA_BITS-1:0] expected_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5A3C_96E1 ^ {a[28:0], 3'b000};
    endfunction

    assign word_addr = {cur_addr[`ICACHE_ADDR_BITS-1:2], 2'b00};
    assign cur_index = cur_addr[`ICACHE_INDEX_BITS+1:2];
    assign cur_tag   = cur_addr[`ICACHE_ADDR_BITS-1:`ICACHE_INDEX_BITS+2];

    always @(posedge clk)
    begin
        if (rst)
        begin
            busy  = 1'b0;
            errs  = 0;
            resps = 0;
            for (i = 0; i < `ICACHE_LINES; i++)
            begin
                shadow_valid[i] = 1'b0;
            end
        end
        else
        begin
            if (busy)
            begin
                lat++;
                if (cpu_req_ready)
                begin
                    errs++;
                    $display("cpu_req_ready went high while a fetch was outstanding");
                end
                if (mem_req_valid && mem_req_ready)
                begin
                    mem_count++;
                    if (expect_hit)
                    begin
                        errs++;
                        $display("Memory request issued for a fetch that should hit");
                    end
                    else if (mem_req_addr !== word_addr)
                    begin
                        errs++;
                        $display("** Error mem_req_addr: expected %h, got %h",
                                 word_addr, mem_req_addr);
                    end
                end
                if (cpu_resp_valid)
                begin
                    resps++;
                    busy = 1'b0;
                    if (cpu_resp_data !== expected_word(word_addr))
                    begin
                        errs++;
                        $display("** Error cpu_resp_data: expected %h, got %h",
                                 expected_word(word_addr), cpu_resp_data);
                    end
                    if (expect_hit && lat != 2)
                    begin
                        errs++;
                        $display("Hit answered after %0d cycles instead of 2", lat);
                    end
                    if (!expect_hit)
                    begin
                        if (mem_count != 1)
                        begin
                            errs++;
                            $display("Miss answered after %0d memory requests instead of 1",
                                     mem_count);
                        end
                        shadow_valid[cur_index] = 1'b1;
                        shadow_tag[cur_index]   = cur_tag;
                    end
                end
                else if (lat > MAX_WAIT)
                begin
                    errs++;
                    busy = 1'b0;
                    $display("No response within %0d cycles of acceptance", MAX_WAIT);
                end
            end
            else if (cpu_resp_valid)
            begin
                errs++;
                $display("Response strobe seen with no fetch outstanding");
            end
            else if (mem_req_valid && mem_req_ready)
            begin
                errs++;
                $display("Memory request completed with no fetch outstanding");
            end

            if (cpu_req_valid && cpu_req_ready)
            begin
                busy       = 1'b1;
                cur_addr   = cpu_req_addr;
                lat        = 0;
                mem_count  = 0;
                expect_hit = shadow_valid[cur_addr[`ICACHE_INDEX_BITS+1:2]] &&
                    (shadow_tag[cur_addr[`ICACHE_INDEX_BITS+1:2]] ==
                     cur_addr[`ICACHE_ADDR_BITS-1:`ICACHE_INDEX_BITS+2]);
            end
        end
        error_count <= errs;
        resp_count  <= resps;
    end

endmodule

/* sim/icache_asserts.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_asserts (
    input logic                         clk,
    input logic                         rst,
    input logic                         cpu_req_ready,
    input logic                         cpu_resp_valid,
    input logic [`ICACHE_ADDR_BITS-1:0] mem_req_addr,
    input logic                         mem_req_valid,
    input logic                         mem_req_ready
);

    int unsigned fail_count;

    initial
    begin
        fail_count = 0;
    end

    // Refill request held with a fixed address until memory takes it
    mem_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr)
    )
    else
    begin
        fail_count++;
        $error("memory request dropped or changed before mem_req_ready");
    end

    resp_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        cpu_resp_valid |=> !cpu_resp_valid
    )
    else
    begin
        fail_count++;
        $error("cpu_resp_valid held for more than one cycle");
    end

    // No new fetch is taken while a refill is pending
    ready_during_refill: assert property (
        @(posedge clk) disable iff (rst)
        !(cpu_req_ready && mem_req_valid)
    )
    else
    begin
        fail_count++;
        $error("cpu_req_ready and mem_req_valid high in the same cycle");
    end

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_top (
    input  logic                         clk,
    input  logic                         rst,

    // CPU fetch port
    input  logic [`ICACHE_ADDR_BITS-1:0] cpu_req_addr,
    input  logic                         cpu_req_valid,
    output logic                         cpu_req_ready,
    output logic [`ICACHE_DATA_BITS-1:0] cpu_resp_data,
    output logic                         cpu_resp_valid,

    // Memory refill port
    output logic [`ICACHE_ADDR_BITS-1:0] mem_req_addr,
    output logic                         mem_req_valid,
    input  logic                         mem_req_ready,
    input  logic [`ICACHE_DATA_BITS-1:0] mem_req_data
);

    icache_array_if array_bus ();

    icache_ctrl ctrl0 (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_data  (cpu_resp_data),
        .cpu_resp_valid (cpu_resp_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_data   (mem_req_data),
        .bus            (array_bus)
    );

    icache_array array0 (
        .clk (clk),
        .rst (rst),
        .bus (array_bus)
    );

endmodule

/* hdl/icache_ctrl.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_ctrl (
    input  logic                         clk,
    input  logic                         rst,

    // CPU fetch port
    input  logic [`ICACHE_ADDR_BITS-1:0] cpu_req_addr,
    input  logic                         cpu_req_valid,
    output logic                         cpu_req_ready,
    output logic [`ICACHE_DATA_BITS-1:0] cpu_resp_data,
    output logic                         cpu_resp_valid,

    // Memory refill port
    output logic [`ICACHE_ADDR_BITS-1:0] mem_req_addr,
    output logic                         mem_req_valid,
    input  logic                         mem_req_ready,
    input  logic [`ICACHE_DATA_BITS-1:0] mem_req_data,

    icache_array_if.ctrl                 bus
);

    icache_pkg::ctrl_state_e      state_q;
    icache_pkg::ctrl_state_e      state_d;
    icache_pkg::fetch_addr_u      req_addr;
    icache_pkg::fetch_addr_u      addr_q;
    logic [`ICACHE_DATA_BITS-1:0] resp_data_q;
    logic                         accept;
    logic                         hit;
    logic                         refill_done;

    assign req_addr.raw = cpu_req_addr;

    assign cpu_req_ready = (state_q == icache_pkg::IDLE);
    assign accept        = cpu_req_valid && cpu_req_ready;

    // Array outputs are valid in LOOKUP for the line indexed at acceptance
    assign hit = bus.rd_valid && (bus.rd_tag == addr_q.f.tag);

    assign refill_done = (state_q == icache_pkg::REFILL) && mem_req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= icache_pkg::IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE:
            begin
                if (cpu_req_valid)
                begin
                    state_d = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP:
            begin
                if (hit)
                begin
                    state_d = icache_pkg::RESPOND;
                end
                else
                begin
                    state_d = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL:
            begin
                // Stall here as long as memory needs
                if (mem_req_ready)
                begin
                    state_d = icache_pkg::RESPOND;
                end
            end
            icache_pkg::RESPOND:
            begin
                state_d = icache_pkg::IDLE;
            end
            default:
            begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    // Request address held for the whole transaction
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q <= req_addr;
        end
    end

    // Index from the incoming request while idle so the read lands in LOOKUP
    always_comb
    begin
        if (state_q == icache_pkg::IDLE)
        begin
            bus.rd_index = req_addr.f.index;
        end
        else
        begin
            bus.rd_index = addr_q.f.index;
        end
    end

    // Refill write
    assign bus.wr_en    = refill_done;
    assign bus.wr_index = addr_q.f.index;
    assign bus.wr_tag   = addr_q.f.tag;
    assign bus.wr_data  = mem_req_data;

    // Word aligned memory request
    assign mem_req_valid = (state_q == icache_pkg::REFILL);
    assign mem_req_addr  = {addr_q.raw[`ICACHE_ADDR_BITS-1:2], 2'b00};

    // Response word comes from the array on a hit, from memory on a refill
    always_ff @(posedge clk)
    begin
        if ((state_q == icache_pkg::LOOKUP) && hit)
        begin
            resp_data_q <= bus.rd_data;
        end
        else if (refill_done)
        begin
            resp_data_q <= mem_req_data;
        end
    end

    assign cpu_resp_valid = (state_q == icache_pkg::RESPOND);
    assign cpu_resp_data  = resp_data_q;

endmodule

/* hdl/icache_array.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_array (
    input logic           clk,
    input logic           rst,
    icache_array_if.array bus
);

    logic [`ICACHE_LINES-1:0]     valid_q;
    icache_pkg::tag_t             tag_mem [`ICACHE_LINES];
    logic [`ICACHE_DATA_BITS-1:0] data_mem [`ICACHE_LINES];

    // Valid bits are set by a refill and cleared only by reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (bus.wr_en)
        begin
            valid_q[bus.wr_index] <= 1'b1;
        end
    end

    // Tag and data storage
    always_ff @(posedge clk)
    begin
        if (bus.wr_en)
        begin
            tag_mem[bus.wr_index]  <= bus.wr_tag;
            data_mem[bus.wr_index] <= bus.wr_data;
        end
    end

    // Registered read
    // a write to the same line in this cycle is not seen until the next read
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bus.rd_valid <= 1'b0;
        end
        else
        begin
            bus.rd_valid <= valid_q[bus.rd_index];
        end
    end

    always_ff @(posedge clk)
    begin
        bus.rd_tag  <= tag_mem[bus.rd_index];
        bus.rd_data <= data_mem[bus.rd_index];
    end

endmodule

/* hdl/icache_array_if.sv */
`timescale 1ns/1ns
`include "icache_settings.svh"

interface icache_array_if;

    // Read port with one cycle from index to line contents
    icache_pkg::index_t           rd_index;
    logic                         rd_valid;
    icache_pkg::tag_t             rd_tag;
    logic [`ICACHE_DATA_BITS-1:0] rd_data;

    // Refill write port
    logic                         wr_en;
    icache_pkg::index_t           wr_index;
    icache_pkg::tag_t             wr_tag;
    logic [`ICACHE_DATA_BITS-1:0] wr_data;

    modport ctrl (
        output rd_index,
        input  rd_valid,
        input  rd_tag,
        input  rd_data,
        output wr_en,
        output wr_index,
        output wr_tag,
        output wr_data
    );

    modport array (
        input  rd_index,
        output rd_valid,
        output rd_tag,
        output rd_data,
        input  wr_en,
        input  wr_index,
        input  wr_tag,
        input  wr_data
    );

endinterface

/* hdl/icache_pkg.sv */
`include "icache_settings.svh"

package icache_pkg;

    // Address split into tag, index and byte offset
    typedef logic [`ICACHE_ADDR_BITS-`ICACHE_INDEX_BITS-3:0] tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

    typedef struct packed {
        tag_t       tag;
        index_t     index;
        logic [1:0] offset;
    } fetch_fields_t;

    // Same fetch address seen as a raw word or as its fields
    typedef union packed {
        logic [`ICACHE_ADDR_BITS-1:0] raw;
        fetch_fields_t                f;
    } fetch_addr_u;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOOKUP  = 2'd1,
        REFILL  = 2'd2,
        RESPOND = 2'd3
    } ctrl_state_e;

endpackage

/* include/icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Fetch address width shared by the CPU and memory sides
`define ICACHE_ADDR_BITS 32

// One instruction word per line
`define ICACHE_DATA_BITS 32

// Direct mapped with 16 lines
`define ICACHE_INDEX_BITS 4
`define ICACHE_LINES 16

`endif
